// File: hdl/surf_ctrl_pkg.sv
package surf_ctrl_pkg;

	// Bus widths.
	localparam int DATA_W = 32;
	localparam int ADDR_W = 16;
	localparam int STRB_W = DATA_W / 8;

	// Region select lives in the top nibble of the byte address.
	localparam int REGION_LSB = 12;
	localparam int REGION_W = ADDR_W - REGION_LSB;
	// Offset inside a region, as carried on the internal register bus.
	localparam int OFS_W = REGION_LSB;

	// Region numbers.
	localparam logic [REGION_W-1:0] REGION_ID = REGION_W'(0);
	localparam logic [REGION_W-1:0] REGION_TRACE = REGION_W'(1);

	// ID/control register offsets.
	localparam logic [OFS_W-1:0] VERSION_OFS = 12'h000;
	localparam logic [OFS_W-1:0] SCRATCH_OFS = 12'h004;
	localparam logic [OFS_W-1:0] CONTROL_OFS = 12'h008;
	localparam logic [OFS_W-1:0] STATUS_OFS = 12'h00C;

	// Trace region offsets, 8 bytes per entry from the entry base.
	localparam logic [OFS_W-1:0] TRACE_COUNT_OFS = 12'h000;
	localparam logic [OFS_W-1:0] TRACE_ENTRY_BASE = 12'h100;

	// Firmware version fields, most significant first.
	localparam logic [3:0] BOARD_REV = 4'h1;
	localparam logic [3:0] VER_MONTH = 4'd6;
	localparam logic [7:0] VER_DAY = 8'd27;
	localparam logic [3:0] VER_MAJOR = 4'd0;
	localparam logic [3:0] VER_MINOR = 4'd2;
	localparam logic [7:0] VER_REVISION = 8'd11;
	localparam logic [DATA_W-1:0] VERSION_WORD = {BOARD_REV, VER_MONTH, VER_DAY,
		VER_MAJOR, VER_MINOR, VER_REVISION};

	// CONTROL register fields.
	localparam int CTRL_LED_LSB = 0;
	localparam int CTRL_LED_W = 4;
	localparam int CTRL_TIMING_EN_BIT = 8;

	// Sync period counter width, as read from STATUS.
	localparam int SYNC_CNT_W = 16;

	// Bus controller states.
	typedef enum logic [1:0] {IDLE, ACCESS, WAIT_ACK, RESP} bus_state_t;

	// AXI response codes.
	typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} resp_t;

endpackage

// File: hdl/reg_bus_if.sv
`timescale 1ns/100ps

interface reg_bus_if;

	// Request side, one-cycle strobe with qualifiers.
	logic req;
	logic we;
	logic [surf_ctrl_pkg::OFS_W-1:0] addr;
	logic [surf_ctrl_pkg::DATA_W-1:0] wdata;
	logic [surf_ctrl_pkg::STRB_W-1:0] wstrb;

	// Answer side, one cycle after req.
	logic ack;
	logic err;
	logic [surf_ctrl_pkg::DATA_W-1:0] rdata;

	// Bus controller view.
	modport ctrl(output req, we, addr, wdata, wstrb, input ack, err, rdata);

	// Register block view.
	modport target(input req, we, addr, wdata, wstrb, output ack, err, rdata);

endinterface

// File: hdl/bus_ctrl.sv
`timescale 1ns/100ps

module bus_ctrl (
	input  logic sys_clk,
	input  logic rst_n_i,
	// AXI4-Lite write address.
	input  logic [surf_ctrl_pkg::ADDR_W-1:0] s_awaddr_i,
	input  logic s_awvalid_i,
	output logic s_awready_o,
	// AXI4-Lite write data.
	input  logic [surf_ctrl_pkg::DATA_W-1:0] s_wdata_i,
	input  logic [surf_ctrl_pkg::STRB_W-1:0] s_wstrb_i,
	input  logic s_wvalid_i,
	output logic s_wready_o,
	// AXI4-Lite write response.
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input  logic s_bready_i,
	// AXI4-Lite read address.
	input  logic [surf_ctrl_pkg::ADDR_W-1:0] s_araddr_i,
	input  logic s_arvalid_i,
	output logic s_arready_o,
	// AXI4-Lite read data.
	output logic [surf_ctrl_pkg::DATA_W-1:0] s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input  logic s_rready_i,
	// Register regions.
	reg_bus_if.ctrl id_bus,
	reg_bus_if.ctrl trace_bus,
	// Capture channel into the trace buffer.
	output logic cap_valid_o,
	output logic cap_we_o,
	output logic [surf_ctrl_pkg::ADDR_W-1:0] cap_addr_o,
	output logic [surf_ctrl_pkg::DATA_W-1:0] cap_data_o
);

	surf_ctrl_pkg::bus_state_t state_q;
	surf_ctrl_pkg::resp_t resp_q;
	logic we_q;
	logic sel_trace_q;
	logic [surf_ctrl_pkg::ADDR_W-1:0] addr_q;
	logic [surf_ctrl_pkg::DATA_W-1:0] wdata_q;
	logic [surf_ctrl_pkg::STRB_W-1:0] wstrb_q;
	logic [surf_ctrl_pkg::DATA_W-1:0] rdata_q;
	logic aw_take;
	logic ar_take;
	logic [surf_ctrl_pkg::ADDR_W-1:0] new_addr;
	logic [surf_ctrl_pkg::REGION_W-1:0] region;
	logic region_ok;
	logic sel_ack;
	logic sel_err;
	logic [surf_ctrl_pkg::DATA_W-1:0] sel_rdata;

	// Write needs both AW and W; it also wins a tie with AR.
	assign aw_take = (state_q == surf_ctrl_pkg::IDLE) && s_awvalid_i && s_wvalid_i;
	// Read only when no write is on its way.
	assign ar_take = (state_q == surf_ctrl_pkg::IDLE) && s_arvalid_i
		&& !s_awvalid_i && !s_wvalid_i;

	assign s_awready_o = aw_take;
	assign s_wready_o = aw_take;
	assign s_arready_o = ar_take;

	// Region decode on the incoming address.
	assign new_addr = aw_take ? s_awaddr_i : s_araddr_i;
	assign region = new_addr[surf_ctrl_pkg::ADDR_W-1:surf_ctrl_pkg::REGION_LSB];
	assign region_ok = (region == surf_ctrl_pkg::REGION_ID)
		|| (region == surf_ctrl_pkg::REGION_TRACE);

	// Answer from whichever region was addressed.
	assign sel_ack = sel_trace_q ? trace_bus.ack : id_bus.ack;
	assign sel_err = sel_trace_q ? trace_bus.err : id_bus.err;
	assign sel_rdata = sel_trace_q ? trace_bus.rdata : id_bus.rdata;

	// Controller FSM.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			state_q <= surf_ctrl_pkg::IDLE;
			resp_q <= surf_ctrl_pkg::OKAY;
			we_q <= 1'b0;
			sel_trace_q <= 1'b0;
		end else begin
			case (state_q)
				surf_ctrl_pkg::IDLE: begin
					if (aw_take || ar_take) begin
						we_q <= aw_take;
						sel_trace_q <= (region == surf_ctrl_pkg::REGION_TRACE);
						// Undecoded region skips the request.
						if (region_ok) begin
							state_q <= surf_ctrl_pkg::ACCESS;
						end else begin
							resp_q <= surf_ctrl_pkg::SLVERR;
							state_q <= surf_ctrl_pkg::RESP;
						end
					end
				end
				surf_ctrl_pkg::ACCESS: begin
					state_q <= surf_ctrl_pkg::WAIT_ACK;
				end
				surf_ctrl_pkg::WAIT_ACK: begin
					if (sel_ack) begin
						resp_q <= sel_err ? surf_ctrl_pkg::SLVERR : surf_ctrl_pkg::OKAY;
						state_q <= surf_ctrl_pkg::RESP;
					end
				end
				default: begin
					// Hold the response until the master takes it.
					if (we_q ? s_bready_i : s_rready_i) begin
						state_q <= surf_ctrl_pkg::IDLE;
					end
				end
			endcase
		end
	end

	// Latched access and read data.
	always_ff @(posedge sys_clk) begin
		if (aw_take || ar_take) begin
			addr_q <= new_addr;
			wdata_q <= s_wdata_i;
			wstrb_q <= s_wstrb_i;
			rdata_q <= '0;
		end else if ((state_q == surf_ctrl_pkg::WAIT_ACK) && sel_ack) begin
			rdata_q <= sel_err ? '0 : sel_rdata;
		end
	end

	// One request strobe, steered to the chosen region.
	assign id_bus.req = (state_q == surf_ctrl_pkg::ACCESS) && !sel_trace_q;
	assign trace_bus.req = (state_q == surf_ctrl_pkg::ACCESS) && sel_trace_q;
	assign id_bus.we = we_q;
	assign trace_bus.we = we_q;
	assign id_bus.addr = addr_q[surf_ctrl_pkg::OFS_W-1:0];
	assign trace_bus.addr = addr_q[surf_ctrl_pkg::OFS_W-1:0];
	assign id_bus.wdata = wdata_q;
	assign trace_bus.wdata = wdata_q;
	assign id_bus.wstrb = wstrb_q;
	assign trace_bus.wstrb = wstrb_q;

	// Response channels.
	assign s_bvalid_o = (state_q == surf_ctrl_pkg::RESP) && we_q;
	assign s_rvalid_o = (state_q == surf_ctrl_pkg::RESP) && !we_q;
	assign s_bresp_o = resp_q;
	assign s_rresp_o = resp_q;
	assign s_rdata_o = rdata_q;

	// Trace capture of clean ID-region accesses.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			cap_valid_o <= 1'b0;
		end else begin
			cap_valid_o <= (state_q == surf_ctrl_pkg::WAIT_ACK) && sel_ack
				&& !sel_err && !sel_trace_q;
		end
	end

	// Capture payload, write data or returned read data.
	always_ff @(posedge sys_clk) begin
		cap_we_o <= we_q;
		cap_addr_o <= addr_q;
		cap_data_o <= we_q ? wdata_q : sel_rdata;
	end

endmodule

// File: hdl/id_ctrl_regs.sv
`timescale 1ns/100ps

module id_ctrl_regs (
	input  logic sys_clk,
	input  logic rst_n_i,
	reg_bus_if.target bus_i,
	input  logic [surf_ctrl_pkg::SYNC_CNT_W-1:0] sync_count_i,
	output logic [surf_ctrl_pkg::CTRL_LED_W-1:0] led_o,
	output logic timing_en_o
);

	logic [surf_ctrl_pkg::DATA_W-1:0] scratch_q;
	logic [surf_ctrl_pkg::DATA_W-1:0] control_q;
	logic [surf_ctrl_pkg::DATA_W-1:0] rdata_q;
	logic ack_q;
	logic err_q;
	logic mapped;
	logic wr_scratch;
	logic wr_control;

	// Offset decode.
	assign mapped = (bus_i.addr == surf_ctrl_pkg::VERSION_OFS)
		|| (bus_i.addr == surf_ctrl_pkg::SCRATCH_OFS)
		|| (bus_i.addr == surf_ctrl_pkg::CONTROL_OFS)
		|| (bus_i.addr == surf_ctrl_pkg::STATUS_OFS);
	assign wr_scratch = bus_i.req && bus_i.we && (bus_i.addr == surf_ctrl_pkg::SCRATCH_OFS);
	assign wr_control = bus_i.req && bus_i.we && (bus_i.addr == surf_ctrl_pkg::CONTROL_OFS);

	// Acknowledge one cycle after the request.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= bus_i.req;
			err_q <= bus_i.req && !mapped;
		end
	end

	// Scratch word, byte lanes under wstrb.
	always_ff @(posedge sys_clk) begin
		for (int b = 0; b < surf_ctrl_pkg::STRB_W; b++) begin
			if (wr_scratch && bus_i.wstrb[b]) begin
				scratch_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
			end
		end
	end

	// Control word.
	// LEDs and timing enable must come up off.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			control_q <= '0;
		end else begin
			for (int b = 0; b < surf_ctrl_pkg::STRB_W; b++) begin
				if (wr_control && bus_i.wstrb[b]) begin
					control_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
				end
			end
		end
	end

	// Read mux, registered with the ack.
	always_ff @(posedge sys_clk) begin
		if (bus_i.req) begin
			case (bus_i.addr)
				surf_ctrl_pkg::VERSION_OFS: rdata_q <= surf_ctrl_pkg::VERSION_WORD;
				surf_ctrl_pkg::SCRATCH_OFS: rdata_q <= scratch_q;
				surf_ctrl_pkg::CONTROL_OFS: rdata_q <= control_q;
				surf_ctrl_pkg::STATUS_OFS: rdata_q <= surf_ctrl_pkg::DATA_W'(sync_count_i);
				default: rdata_q <= '0;
			endcase
		end
	end

	assign bus_i.ack = ack_q;
	assign bus_i.err = err_q;
	assign bus_i.rdata = rdata_q;

	// Control fields out to the board.
	assign led_o = control_q[surf_ctrl_pkg::CTRL_LED_LSB +: surf_ctrl_pkg::CTRL_LED_W];
	assign timing_en_o = control_q[surf_ctrl_pkg::CTRL_TIMING_EN_BIT];

endmodule

// File: hdl/sst_timing.sv
`timescale 1ns/100ps

module sst_timing #(
	parameter int SYNC_PERIODS = 8
) (
	input  logic sys_clk,
	input  logic rst_n_i,
	input  logic enable_i,
	output logic sst_o,
	output logic sync_o,
	output logic [surf_ctrl_pkg::SYNC_CNT_W-1:0] sync_count_o
);

	// Wide enough to count to SYNC_PERIODS-1.
	localparam int PER_W = (SYNC_PERIODS > 1) ? $clog2(SYNC_PERIODS) : 1;

	logic [1:0] phase_q;
	logic div4_flag_q;
	logic [1:0] div4_delay_q;
	logic sst_q;
	logic sync_q;
	logic [PER_W-1:0] period_q;
	logic [surf_ctrl_pkg::SYNC_CNT_W-1:0] sync_count_q;

	// Disable parks the whole block at zero.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i || !enable_i) begin
			phase_q <= 2'd0;
			div4_flag_q <= 1'b0;
			div4_delay_q <= 2'd0;
			sst_q <= 1'b0;
			sync_q <= 1'b0;
			period_q <= '0;
			sync_count_q <= '0;
		end else begin
			phase_q <= phase_q + 2'd1;
			// Flag marks the first clock of each 4-clock period.
			div4_flag_q <= (phase_q == 2'd3);
			div4_delay_q <= {div4_delay_q[0], div4_flag_q};
			// Stretch the flag into a half-duty SST copy.
			if (div4_flag_q) begin
				sst_q <= 1'b1;
			end else if (div4_delay_q[1]) begin
				sst_q <= 1'b0;
			end
			// Count phase wraps into sync half-periods.
			if (phase_q == 2'd3) begin
				if (period_q == PER_W'(SYNC_PERIODS - 1)) begin
					period_q <= '0;
					sync_q <= ~sync_q;
					sync_count_q <= sync_count_q + surf_ctrl_pkg::SYNC_CNT_W'(1);
				end else begin
					period_q <= period_q + PER_W'(1);
				end
			end
		end
	end

	assign sst_o = sst_q;
	assign sync_o = sync_q;
	assign sync_count_o = sync_count_q;

endmodule

// File: hdl/bus_trace.sv
`timescale 1ns/100ps

module bus_trace #(
	parameter int TRACE_DEPTH = 16
) (
	input  logic sys_clk,
	input  logic rst_n_i,
	reg_bus_if.target bus_i,
	input  logic cap_valid_i,
	input  logic cap_we_i,
	input  logic [surf_ctrl_pkg::ADDR_W-1:0] cap_addr_i,
	input  logic [surf_ctrl_pkg::DATA_W-1:0] cap_data_i
);

	localparam int PTR_W = $clog2(TRACE_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	// First offset past the last entry.
	localparam int ENTRY_END = int'(surf_ctrl_pkg::TRACE_ENTRY_BASE) + 8 * TRACE_DEPTH;
	// Zero fill between the write flag and the address.
	localparam int PAD_W = surf_ctrl_pkg::DATA_W - 1 - surf_ctrl_pkg::ADDR_W;

	// Capture memory with one slot per access.
	logic mem_we [TRACE_DEPTH];
	logic [surf_ctrl_pkg::ADDR_W-1:0] mem_addr [TRACE_DEPTH];
	logic [surf_ctrl_pkg::DATA_W-1:0] mem_data [TRACE_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic [surf_ctrl_pkg::DATA_W-1:0] rdata_q;
	logic ack_q;
	logic err_q;
	logic is_count;
	logic in_entries;
	logic clear;
	logic [surf_ctrl_pkg::OFS_W-1:0] ent_ofs;
	logic [PTR_W-1:0] ent_idx;
	logic [PTR_W-1:0] rd_ptr;

	// Offset decode.
	assign is_count = (bus_i.addr == surf_ctrl_pkg::TRACE_COUNT_OFS);
	assign in_entries = (bus_i.addr >= surf_ctrl_pkg::TRACE_ENTRY_BASE)
		&& (int'(bus_i.addr) < ENTRY_END);
	assign clear = bus_i.req && bus_i.we && is_count;

	// Entry 0 is the oldest stored access.
	assign ent_ofs = bus_i.addr - surf_ctrl_pkg::TRACE_ENTRY_BASE;
	assign ent_idx = ent_ofs[3 +: PTR_W];
	assign rd_ptr = wr_ptr_q - count_q[PTR_W-1:0] + ent_idx;

	// Write pointer wraps; count saturates at the depth.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i || clear) begin
			wr_ptr_q <= '0;
			count_q <= '0;
		end else if (cap_valid_i) begin
			wr_ptr_q <= wr_ptr_q + PTR_W'(1);
			if (count_q != CNT_W'(TRACE_DEPTH)) begin
				count_q <= count_q + CNT_W'(1);
			end
		end
	end

	// Store the access. Oldest slot is overwritten when full.
	always_ff @(posedge sys_clk) begin
		if (cap_valid_i) begin
			mem_we[wr_ptr_q] <= cap_we_i;
			mem_addr[wr_ptr_q] <= cap_addr_i;
			mem_data[wr_ptr_q] <= cap_data_i;
		end
	end

	// Acknowledge one cycle after the request.
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= bus_i.req;
			err_q <= bus_i.req && !(is_count || in_entries);
		end
	end

	// Readback where bit 2 picks the address word or the data word.
	always_ff @(posedge sys_clk) begin
		if (bus_i.req) begin
			if (is_count) begin
				rdata_q <= surf_ctrl_pkg::DATA_W'(count_q);
			end else if (in_entries && ent_ofs[2]) begin
				rdata_q <= mem_data[rd_ptr];
			end else if (in_entries) begin
				rdata_q <= {mem_we[rd_ptr], {PAD_W{1'b0}}, mem_addr[rd_ptr]};
			end else begin
				rdata_q <= '0;
			end
		end
	end

	assign bus_i.ack = ack_q;
	assign bus_i.err = err_q;
	assign bus_i.rdata = rdata_q;

endmodule

// File: hdl/surf_ctrl_top.sv
`timescale 1ns/100ps

module surf_ctrl_top #(
	parameter int TRACE_DEPTH = 16,
	parameter int SYNC_PERIODS = 8
) (
	input  logic sys_clk,
	input  logic rst_n_i,
	input  logic [surf_ctrl_pkg::ADDR_W-1:0] s_awaddr_i,
	input  logic s_awvalid_i,
	output logic s_awready_o,
	input  logic [surf_ctrl_pkg::DATA_W-1:0] s_wdata_i,
	input  logic [surf_ctrl_pkg::STRB_W-1:0] s_wstrb_i,
	input  logic s_wvalid_i,
	output logic s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input  logic s_bready_i,
	input  logic [surf_ctrl_pkg::ADDR_W-1:0] s_araddr_i,
	input  logic s_arvalid_i,
	output logic s_arready_o,
	output logic [surf_ctrl_pkg::DATA_W-1:0] s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input  logic s_rready_i,
	output logic [surf_ctrl_pkg::CTRL_LED_W-1:0] led_o,
	output logic sst_o,
	output logic sync_o
);

	// One register bus per region.
	reg_bus_if id_bus ();
	reg_bus_if trace_bus ();

	logic cap_valid;
	logic cap_we;
	logic [surf_ctrl_pkg::ADDR_W-1:0] cap_addr;
	logic [surf_ctrl_pkg::DATA_W-1:0] cap_data;
	logic timing_en;
	logic [surf_ctrl_pkg::SYNC_CNT_W-1:0] sync_count;

	// AXI slave and region decode.
	bus_ctrl u_bus_ctrl (
		.sys_clk(sys_clk), .rst_n_i(rst_n_i),
		.s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.id_bus(id_bus.ctrl), .trace_bus(trace_bus.ctrl),
		.cap_valid_o(cap_valid), .cap_we_o(cap_we),
		.cap_addr_o(cap_addr), .cap_data_o(cap_data)
	);

	// Version, scratch, control and status.
	id_ctrl_regs u_id_ctrl_regs (
		.sys_clk(sys_clk), .rst_n_i(rst_n_i), .bus_i(id_bus.target),
		.sync_count_i(sync_count), .led_o(led_o), .timing_en_o(timing_en)
	);

	// Record of ID-region accesses.
	bus_trace #(.TRACE_DEPTH(TRACE_DEPTH)) u_bus_trace (
		.sys_clk(sys_clk), .rst_n_i(rst_n_i), .bus_i(trace_bus.target),
		.cap_valid_i(cap_valid), .cap_we_i(cap_we),
		.cap_addr_i(cap_addr), .cap_data_i(cap_data)
	);

	// SST and sync phase generation.
	sst_timing #(.SYNC_PERIODS(SYNC_PERIODS)) u_sst_timing (
		.sys_clk(sys_clk), .rst_n_i(rst_n_i), .enable_i(timing_en),
		.sst_o(sst_o), .sync_o(sync_o), .sync_count_o(sync_count)
	);

endmodule

// File: verif/surf_ctrl_tb_tasks.svh
`ifndef SURF_CTRL_TB_TASKS_SVH
`define SURF_CTRL_TB_TASKS_SVH

// Ends the run at the first error.
task automatic stop_with_error(input string what);
	$display("%s", what);
	$display("tests failed");
	$fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		stop_with_error($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp));
	end
endtask

// AXI write. Bready stays low for hold cycles after bvalid rises.
task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
	input logic [3:0] strb, input int hold, output logic [1:0] resp);
	int waited;
	@(negedge sys_clk);
	s_awaddr_i = addr;
	s_wdata_i = data;
	s_wstrb_i = strb;
	s_awvalid_i = 1'b1;
	s_wvalid_i = 1'b1;
	waited = 0;
	// Readies follow the valids combinationally and are sampled just after the edge.
	#1;
	while (!s_awready_o) begin
		@(negedge sys_clk);
		#1;
		waited++;
		if (waited > TIMEOUT) begin
			stop_with_error("timeout: write address and data were never accepted");
		end
	end
	// Both channels are taken in the same cycle.
	check_value("s_wready_o", 32'(s_wready_o), 32'd1);
	@(negedge sys_clk);
	s_awvalid_i = 1'b0;
	s_wvalid_i = 1'b0;
	waited = 0;
	while (!s_bvalid_o) begin
		@(negedge sys_clk);
		waited++;
		if (waited > TIMEOUT) begin
			stop_with_error("timeout: no write response arrived");
		end
	end
	resp = s_bresp_o;
	// Response must wait for the master.
	for (int i = 0; i < hold; i++) begin
		@(negedge sys_clk);
		check_value("s_bvalid_o", 32'(s_bvalid_o), 32'd1);
	end
	s_bready_i = 1'b1;
	@(negedge sys_clk);
	s_bready_i = 1'b0;
	check_value("s_bvalid_o", 32'(s_bvalid_o), 32'd0);
endtask

// AXI read. Rready stays low for hold cycles after rvalid rises.
task automatic axil_read(input logic [15:0] addr, input int hold,
	output logic [31:0] data, output logic [1:0] resp);
	int waited;
	@(negedge sys_clk);
	s_araddr_i = addr;
	s_arvalid_i = 1'b1;
	waited = 0;
	#1;
	while (!s_arready_o) begin
		@(negedge sys_clk);
		#1;
		waited++;
		if (waited > TIMEOUT) begin
			stop_with_error("timeout: read address was never accepted");
		end
	end
	@(negedge sys_clk);
	s_arvalid_i = 1'b0;
	waited = 0;
	while (!s_rvalid_o) begin
		@(negedge sys_clk);
		waited++;
		if (waited > TIMEOUT) begin
			stop_with_error("timeout: no read data arrived");
		end
	end
	data = s_rdata_o;
	resp = s_rresp_o;
	for (int i = 0; i < hold; i++) begin
		@(negedge sys_clk);
		check_value("s_rvalid_o", 32'(s_rvalid_o), 32'd1);
	end
	s_rready_i = 1'b1;
	@(negedge sys_clk);
	s_rready_i = 1'b0;
	check_value("s_rvalid_o", 32'(s_rvalid_o), 32'd0);
endtask

task automatic write_expect(input logic [15:0] addr, input logic [31:0] data,
	input logic [3:0] strb, input logic [1:0] exp_resp);
	logic [1:0] resp;
	axil_write(addr, data, strb, 0, resp);
	check_value($sformatf("s_bresp_o at 0x%04h", addr), 32'(resp), 32'(exp_resp));
endtask

task automatic read_expect(input string name, input logic [15:0] addr,
	input logic [31:0] exp_data, input logic [1:0] exp_resp);
	logic [31:0] data;
	logic [1:0] resp;
	axil_read(addr, 0, data, resp);
	check_value($sformatf("s_rresp_o for %s", name), 32'(resp), 32'(exp_resp));
	check_value($sformatf("s_rdata_o for %s", name), data, exp_data);
endtask

// Outputs right after reset.
task automatic test_reset_state();
	check_value("s_awready_o", 32'(s_awready_o), 32'd0);
	check_value("s_wready_o", 32'(s_wready_o), 32'd0);
	check_value("s_arready_o", 32'(s_arready_o), 32'd0);
	check_value("s_bvalid_o", 32'(s_bvalid_o), 32'd0);
	check_value("s_rvalid_o", 32'(s_rvalid_o), 32'd0);
	check_value("led_o", 32'(led_o), 32'd0);
	check_value("sst_o", 32'(sst_o), 32'd0);
	check_value("sync_o", 32'(sync_o), 32'd0);
endtask

// VERSION is read-only and writes to it still answer OKAY.
task automatic test_version();
	read_expect("VERSION", ADDR_VERSION, EXP_VERSION, RESP_OKAY);
	write_expect(ADDR_VERSION, rand_bits(32), 4'hF, RESP_OKAY);
	read_expect("VERSION", ADDR_VERSION, EXP_VERSION, RESP_OKAY);
endtask

// Byte lanes merged under wstrb.
task automatic test_scratch();
	logic [31:0] data;
	logic [3:0] strb;
	data = rand_bits(32);
	write_expect(ADDR_SCRATCH, data, 4'hF, RESP_OKAY);
	scratch_model = data;
	read_expect("SCRATCH", ADDR_SCRATCH, scratch_model, RESP_OKAY);
	for (int n = 0; n < 8; n++) begin
		data = rand_bits(32);
		strb = 4'(rand_bits(4));
		write_expect(ADDR_SCRATCH, data, strb, RESP_OKAY);
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				scratch_model[8*b +: 8] = data[8*b +: 8];
			end
		end
		read_expect("SCRATCH", ADDR_SCRATCH, scratch_model, RESP_OKAY);
	end
endtask

task automatic test_errors();
	read_expect("undecoded region", 16'h2000, 32'd0, RESP_SLVERR);
	write_expect(16'hF004, rand_bits(32), 4'hF, RESP_SLVERR);
	read_expect("unmapped ID offset", 16'h0010, 32'd0, RESP_SLVERR);
	write_expect(16'h0010, rand_bits(32), 4'hF, RESP_SLVERR);
	// First offset past the last trace entry.
	read_expect("trace past last entry", ADDR_TRACE_ENTRY + 16'(8 * TRACE_DEPTH), 32'd0,
		RESP_SLVERR);
	// Failed write left the scratch word alone.
	read_expect("SCRATCH", ADDR_SCRATCH, scratch_model, RESP_OKAY);
endtask

// LED bits and response back-pressure.
task automatic test_led();
	logic [31:0] data;
	logic [31:0] rdata;
	logic [1:0] resp;
	data = rand_bits(32) & ~(32'h1 << surf_ctrl_pkg::CTRL_TIMING_EN_BIT);
	axil_write(ADDR_CONTROL, data, 4'hF, 5, resp);
	check_value("s_bresp_o", 32'(resp), 32'(RESP_OKAY));
	check_value("led_o", 32'(led_o), 32'(data[3:0]));
	axil_read(ADDR_CONTROL, 4, rdata, resp);
	check_value("s_rresp_o", 32'(resp), 32'(RESP_OKAY));
	check_value("s_rdata_o for CONTROL", rdata, data);
endtask

// Random ID-region access that is also noted in the trace model.
task automatic traced_access();
	logic [31:0] data;
	logic [1:0] kind;
	kind = 2'(rand_bits(2));
	if (kind[1] == 1'b0) begin
		data = rand_bits(32);
		write_expect(ADDR_SCRATCH, data, 4'hF, RESP_OKAY);
		scratch_model = data;
		trace_addr_q.push_back({1'b1, 15'd0, ADDR_SCRATCH});
		trace_data_q.push_back(data);
	end else if (kind[0] == 1'b0) begin
		read_expect("SCRATCH", ADDR_SCRATCH, scratch_model, RESP_OKAY);
		trace_addr_q.push_back({1'b0, 15'd0, ADDR_SCRATCH});
		trace_data_q.push_back(scratch_model);
	end else begin
		read_expect("VERSION", ADDR_VERSION, EXP_VERSION, RESP_OKAY);
		trace_addr_q.push_back({1'b0, 15'd0, ADDR_VERSION});
		trace_data_q.push_back(EXP_VERSION);
	end
endtask

// Count and entries against the newest accesses in the model.
task automatic check_trace();
	int n;
	int first;
	n = (trace_addr_q.size() < TRACE_DEPTH) ? trace_addr_q.size() : TRACE_DEPTH;
	first = trace_addr_q.size() - n;
	read_expect("TRACE_COUNT", ADDR_TRACE_COUNT, 32'(n), RESP_OKAY);
	for (int i = 0; i < n; i++) begin
		read_expect($sformatf("trace entry %0d address", i), ADDR_TRACE_ENTRY + 16'(8 * i),
			trace_addr_q[first + i], RESP_OKAY);
		read_expect($sformatf("trace entry %0d data", i), ADDR_TRACE_ENTRY + 16'(8 * i + 4),
			trace_data_q[first + i], RESP_OKAY);
	end
endtask

task automatic test_trace();
	write_expect(ADDR_TRACE_COUNT, 32'd0, 4'hF, RESP_OKAY);
	trace_addr_q.delete();
	trace_data_q.delete();
	check_trace();
	repeat (5) traced_access();
	// Errored and trace-region accesses are not recorded.
	read_expect("unmapped ID offset", 16'h0010, 32'd0, RESP_SLVERR);
	read_expect("TRACE_COUNT", ADDR_TRACE_COUNT, 32'd5, RESP_OKAY);
	check_trace();
	// Wraps the buffer.
	repeat (TRACE_DEPTH + 3) traced_access();
	check_trace();
endtask

task automatic test_timing();
	logic [31:0] s1;
	logic [31:0] s2;
	logic [1:0] resp;
	int high;
	int toggles;
	logic last_sync;
	write_expect(ADDR_CONTROL, 32'h0000_0105, 4'hF, RESP_OKAY);
	check_value("led_o", 32'(led_o), 32'h5);
	// Let the SST delay line fill.
	repeat (12) @(negedge sys_clk);
	high = 0;
	repeat (40) begin
		@(negedge sys_clk);
		if (sst_o) begin
			high++;
		end
	end
	check_value("sst_o high cycles in 40", 32'(high), 32'd20);
	axil_read(ADDR_STATUS, 0, s1, resp);
	check_value("s_rresp_o for STATUS", 32'(resp), 32'(RESP_OKAY));
	// Three sync half-periods with one sync_o toggle in each.
	toggles = 0;
	last_sync = sync_o;
	repeat (4 * SYNC_PERIODS * 3) begin
		@(negedge sys_clk);
		if (sync_o !== last_sync) begin
			toggles++;
		end
		last_sync = sync_o;
	end
	check_value("sync_o toggles in three half-periods", 32'(toggles), 32'd3);
	axil_read(ADDR_STATUS, 0, s2, resp);
	check_value("s_rresp_o for STATUS", 32'(resp), 32'(RESP_OKAY));
	check_value("STATUS grew by two or more", 32'((s2 - s1) >= 32'd2), 32'd1);
	write_expect(ADDR_CONTROL, 32'h0000_0005, 4'hF, RESP_OKAY);
	@(negedge sys_clk);
	check_value("sst_o", 32'(sst_o), 32'd0);
	check_value("sync_o", 32'(sync_o), 32'd0);
	read_expect("STATUS", ADDR_STATUS, 32'd0, RESP_OKAY);
endtask

`endif

// File: verif/surf_ctrl_tb.sv
`timescale 1ns/100ps

module surf_ctrl_tb;

	localparam int TRACE_DEPTH = 16;
	localparam int SYNC_PERIODS = 8;
	// Cycles a single wait may take.
	localparam int TIMEOUT = 100;

	// Byte addresses on the AXI port.
	localparam logic [15:0] ADDR_VERSION = 16'h0000;
	localparam logic [15:0] ADDR_SCRATCH = 16'h0004;
	localparam logic [15:0] ADDR_CONTROL = 16'h0008;
	localparam logic [15:0] ADDR_STATUS = 16'h000C;
	localparam logic [15:0] ADDR_TRACE_COUNT = 16'h1000;
	localparam logic [15:0] ADDR_TRACE_ENTRY = 16'h1100;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Version word rebuilt from its fields with the most significant first.
	localparam logic [31:0] EXP_VERSION = {surf_ctrl_pkg::BOARD_REV, surf_ctrl_pkg::VER_MONTH,
		surf_ctrl_pkg::VER_DAY, surf_ctrl_pkg::VER_MAJOR, surf_ctrl_pkg::VER_MINOR,
		surf_ctrl_pkg::VER_REVISION};

	logic sys_clk;
	logic rst_n_i;
	logic [15:0] s_awaddr_i;
	logic s_awvalid_i;
	logic s_awready_o;
	logic [31:0] s_wdata_i;
	logic [3:0] s_wstrb_i;
	logic s_wvalid_i;
	logic s_wready_o;
	logic [1:0] s_bresp_o;
	logic s_bvalid_o;
	logic s_bready_i;
	logic [15:0] s_araddr_i;
	logic s_arvalid_i;
	logic s_arready_o;
	logic [31:0] s_rdata_o;
	logic [1:0] s_rresp_o;
	logic s_rvalid_o;
	logic s_rready_i;
	logic [3:0] led_o;
	logic sst_o;
	logic sync_o;

	logic [31:0] lfsr_state;
	// Last value written to SCRATCH.
	logic [31:0] scratch_model;
	// Expected trace words with the oldest access first.
	logic [31:0] trace_addr_q[$];
	logic [31:0] trace_data_q[$];

	surf_ctrl_top #(.TRACE_DEPTH(TRACE_DEPTH), .SYNC_PERIODS(SYNC_PERIODS)) dut_i (
		.sys_clk(sys_clk), .rst_n_i(rst_n_i),
		.s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i), .s_wstrb_i(s_wstrb_i), .s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.led_o(led_o), .sst_o(sst_o), .sync_o(sync_o)
	);

	// 10 ns clock.
	always #5 sys_clk = ~sys_clk;

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit taken.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	`include "surf_ctrl_tb_tasks.svh"

	initial begin
		sys_clk = 1'b0;
		rst_n_i = 1'b0;
		s_awaddr_i = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wstrb_i = '0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b0;
		s_araddr_i = '0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b0;
		lfsr_state = 32'hde6d;
		scratch_model = '0;
		// Reset for 8 rising edges.
		repeat (8) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n_i = 1'b1;
		@(negedge sys_clk);
		test_reset_state();
		test_version();
		test_scratch();
		test_errors();
		test_led();
		test_trace();
		test_timing();
		$display("all tests passed");
		$finish;
	end

endmodule

// File: surf_ctrl_top.f
+incdir+verif
hdl/surf_ctrl_pkg.sv
hdl/reg_bus_if.sv
hdl/bus_ctrl.sv
hdl/id_ctrl_regs.sv
hdl/sst_timing.sv
hdl/bus_trace.sv
hdl/surf_ctrl_top.sv
verif/surf_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then decide from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module surf_ctrl_tb -f surf_ctrl_top.f -o surf_ctrl_sim \
	|| { echo "build failed"; exit 1; }

./obj_dir/surf_ctrl_sim 2>&1 | tee sim.log

grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
